/* include/cmp_defs.svh */
`ifndef CMP_DEFS_SVH
`define CMP_DEFS_SVH

// byte address width of the memory bus
`define CMP_ADDR_W       48
// one cache line per bus beat
`define CMP_LINE_W       512
// 4 KB page = 64 lines of 64 bytes
`define CMP_PAGE_LINES   64
// size classes, indexed by compressed size / 256
`define CMP_SIZE_CLASSES 16
// zspage metadata header in front of the first compressed page
`define CMP_ZS_OFFSET    64
// list entry array, one line per entry
`define CMP_LIST_BASE    48'h0000_0010_0000

`endif

/* src/cmp_pkg.sv */
`default_nettype none
`include "cmp_defs.svh"

package cmp_pkg;

    typedef logic [`CMP_ADDR_W-13:0] way_t;       // 4 KB frame number
    typedef logic [`CMP_ADDR_W-1:0]  byte_addr_t;
    typedef logic [`CMP_LINE_W-1:0]  line_t;
    typedef logic [12:0]             comp_size_t; // up to 64 lines + header
    typedef logic [3:0]              size_idx_t;  // size / 256
    typedef logic [7:0]              entry_id_t;

    // single beat read channel
    typedef struct packed {
        logic       arvalid;
        byte_addr_t addr;
    } rd_req_t;

    typedef struct packed {
        logic       rvalid;
        logic [1:0] rresp;  // nonzero = bus error
        line_t      rdata;
    } rd_resp_t;

    typedef struct packed {
        logic       wvalid;
        byte_addr_t addr;
        line_t      wdata;
    } wr_req_t;

    // sits in the low bits of a list line
    typedef struct packed {
        way_t        way;
        logic [27:0] attr;
    } list_entry_t;

    // zspage metadata, first line of the zspage way
    typedef struct packed {
        way_t       way0;
        way_t       next_way;    // chained way once the zspage overflows
        byte_addr_t free_start;  // start of the last placed page
        comp_size_t last_size;
    } zspg_md_t;

    typedef struct packed {
        logic       update;      // one cycle pulse
        way_t       iway;
        byte_addr_t free_start;
        comp_size_t cpage_size;
        way_t       next_way;
    } zspg_pkt_t;

    typedef enum logic [1:0] {
        UNCOMP,
        IFL_SIZE1,
        NULLIFY
    } list_id_e;

    typedef struct packed {
        logic       tbl_update;  // one cycle pulse
        entry_id_t  entry_id;
        byte_addr_t new_way;
        list_id_e   src_list;
        list_id_e   dst_list;
        size_idx_t  size_idx;
    } tol_upd_t;

    typedef enum logic [3:0] {
        ST_IDLE, ST_PEEK, ST_WAIT_LIST, ST_DECODE,
        ST_FIFO_RST, ST_BURST, ST_COMP_WAIT, ST_LOOKUP,
        ST_PREP_ZSPG, ST_WAIT_ZSPG, ST_MIGRATE, ST_UPD_ATT,
        ST_FINAL_UPD, ST_DONE, ST_SIZE_ERR, ST_BUS_ERR
    } cmp_state_e;

endpackage

`default_nettype wire

/* src/page_line_fifo.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cmp_defs.svh"

module page_line_fifo (
    input  wire                     clk_i,
    input  wire                     rst_ni,
    input  wire                     push,
    input  wire cmp_pkg::line_t     push_data,
    input  wire                     pop,
    output cmp_pkg::line_t          pop_data,
    output logic                    full,
    output logic                    empty,
    input  wire                     ptr_rst
);

    localparam int unsigned AW = $clog2(`CMP_PAGE_LINES);

    // extra msb tells full from empty
    logic [AW:0]    wr_ptr;
    logic [AW:0]    rd_ptr;
    cmp_pkg::line_t mem [`CMP_PAGE_LINES];

    assign empty    = wr_ptr == rd_ptr;
    assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign pop_data = mem[rd_ptr[AW-1:0]];  // show-ahead read

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (ptr_rst) begin
            wr_ptr <= '0;  // drops whatever is left
            rd_ptr <= '0;
        end else begin
            if (push && !full) wr_ptr <= wr_ptr + 1'b1;
            if (pop && !empty) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push && !full) mem[wr_ptr[AW-1:0]] <= push_data;
    end

endmodule

`default_nettype wire

/* src/zero_line_compressor.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cmp_defs.svh"

module zero_line_compressor (
    input  wire                     clk_i,
    input  wire                     rst_ni,
    input  wire                     comp_start,
    output logic                    pop,
    input  wire cmp_pkg::line_t     pop_data,
    input  wire                     empty,
    output logic                    comp_done,
    output cmp_pkg::comp_size_t     comp_size
);

    localparam int unsigned CNT_W = $clog2(`CMP_PAGE_LINES) + 1;

    logic [CNT_W-1:0] line_cnt;  // lines drained so far
    logic [CNT_W-1:0] nz_cnt;    // lines that have to be kept
    logic             page_seen;

    assign page_seen = line_cnt == CNT_W'(`CMP_PAGE_LINES);
    assign pop       = comp_start && !empty && !page_seen;  // one line per cycle

    // done the cycle after the last pop
    assign comp_done = comp_start && page_seen;
    // 64 bytes per kept line plus one 64 byte header line
    assign comp_size = {nz_cnt + CNT_W'(1), 6'b00_0000};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            line_cnt <= '0;
            nz_cnt   <= '0;
        end else if (comp_done) begin
            line_cnt <= '0;  // ready for the next page
            nz_cnt   <= '0;
        end else if (pop) begin
            line_cnt <= line_cnt + 1'b1;
            nz_cnt   <= nz_cnt + CNT_W'(|pop_data);  // zero lines are eliminated
        end
    end

endmodule

`default_nettype wire

/* src/zspg_wr_mngr.sv */
`timescale 1ns/1ps
`default_nettype none

module zspg_wr_mngr (
    input  wire                     clk_i,
    input  wire                     rst_ni,
    input  wire cmp_pkg::zspg_pkt_t zspg_pkt,
    output logic                    wr_ready,
    output logic                    zspg_updated,
    output cmp_pkg::wr_req_t        wr_req,
    input  wire                     wready
);

    cmp_pkg::zspg_pkt_t pkt_q;  // placement being written
    cmp_pkg::zspg_md_t  md;
    logic               wvalid_q;

    // metadata line, zero extended to a full line
    assign md = '{way0:       pkt_q.iway,
                  next_way:   pkt_q.next_way,
                  free_start: pkt_q.free_start,
                  last_size:  pkt_q.cpage_size};

    // metadata lives at the zspage way base
    assign wr_req = '{wvalid: wvalid_q,
                      addr:   {pkt_q.iway, 12'h000},
                      wdata:  cmp_pkg::line_t'(md)};

    assign wr_ready = !wvalid_q;  // idle

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wvalid_q     <= 1'b0;
            zspg_updated <= 1'b0;
        end else if (zspg_pkt.update) begin
            wvalid_q     <= 1'b1;
            zspg_updated <= 1'b0;  // stale until this write lands
        end else if (wvalid_q && wready) begin
            wvalid_q     <= 1'b0;
            zspg_updated <= 1'b1;  // held until next update pulse
        end
    end

    always_ff @(posedge clk_i) begin
        if (zspg_pkt.update) pkt_q <= zspg_pkt;
    end

endmodule

`default_nettype wire

/* src/cmpresn_mngr.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cmp_defs.svh"

module cmpresn_mngr (
    input  wire                      clk_i,
    input  wire                      rst_ni,
    input  wire                      trigger,
    input  wire cmp_pkg::entry_id_t  list_head,
    output cmp_pkg::rd_req_t         rd_req,
    input  wire                      arready,
    input  wire cmp_pkg::rd_resp_t   rd_resp,
    input  wire                      fifo_full,
    input  wire                      fifo_empty,
    output logic                     fifo_ptr_rst,
    output logic                     comp_start,
    input  wire                      comp_done,
    input  wire cmp_pkg::comp_size_t comp_size,
    input  wire                      wr_ready,
    input  wire                      zspg_updated,
    output cmp_pkg::zspg_pkt_t       zspg_pkt,
    output cmp_pkg::tol_upd_t        tol_upd,
    output logic                     done,
    output cmp_pkg::way_t            free_way,
    output logic                     bus_error,
    output logic                     size_error
);

    localparam int unsigned LW = $clog2(`CMP_PAGE_LINES);

    cmp_pkg::cmp_state_e  state;
    logic                 outstanding;  // a read is in flight
    logic [LW:0]          burst_cnt;    // page lines requested
    logic [`CMP_SIZE_CLASSES-1:0] uc_vld;
    cmp_pkg::way_t        uc_way [`CMP_SIZE_CLASSES];  // open zspage per class

    cmp_pkg::list_entry_t entry;  // page being compressed
    cmp_pkg::comp_size_t  csize;
    cmp_pkg::zspg_md_t    md;     // metadata of the open zspage
    cmp_pkg::size_idx_t   sidx;
    cmp_pkg::byte_addr_t  way_base;
    cmp_pkg::byte_addr_t  zs_next;
    cmp_pkg::byte_addr_t  zs_end;
    logic                 fits;

    assign sidx     = csize[11:8];
    assign way_base = {entry.way, 12'h000};

    // append goes right behind the last placed page
    assign zs_next = md.free_start + cmp_pkg::byte_addr_t'(md.last_size);
    assign zs_end  = zs_next + cmp_pkg::byte_addr_t'(csize);
    assign fits    = zs_end[`CMP_ADDR_W-1:12] == md.way0;  // still inside the 4 KB frame

    assign bus_error  = state == cmp_pkg::ST_BUS_ERR;
    assign size_error = state == cmp_pkg::ST_SIZE_ERR;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state        <= cmp_pkg::ST_IDLE;
            rd_req       <= '0;
            outstanding  <= 1'b0;
            burst_cnt    <= '0;
            fifo_ptr_rst <= 1'b0;
            comp_start   <= 1'b0;
            uc_vld       <= '0;
            zspg_pkt     <= '0;
            tol_upd      <= '0;
            done         <= 1'b0;
            free_way     <= '0;
        end else begin
            fifo_ptr_rst       <= 1'b0;
            zspg_pkt.update    <= 1'b0;
            tol_upd.tbl_update <= 1'b0;
            done               <= 1'b0;

            // read handshake, request held until taken
            if (rd_req.arvalid && arready) begin
                rd_req.arvalid <= 1'b0;
                outstanding    <= 1'b1;
            end
            if (rd_resp.rvalid) outstanding <= 1'b0;

            case (state)
                cmp_pkg::ST_IDLE: begin
                    if (trigger && !done) state <= cmp_pkg::ST_PEEK;
                end
                cmp_pkg::ST_PEEK: begin
                    if (!tol_upd.tbl_update) begin  // let the list head advance first
                        rd_req.arvalid <= 1'b1;
                        rd_req.addr    <= `CMP_LIST_BASE
                                          + cmp_pkg::byte_addr_t'({list_head, 6'b00_0000});
                        state          <= cmp_pkg::ST_WAIT_LIST;
                    end
                end
                cmp_pkg::ST_WAIT_LIST: begin
                    if (rd_resp.rvalid) begin
                        state <= (rd_resp.rresp != '0) ? cmp_pkg::ST_BUS_ERR
                                                       : cmp_pkg::ST_DECODE;
                    end
                end
                cmp_pkg::ST_DECODE: begin
                    burst_cnt    <= '0;
                    fifo_ptr_rst <= 1'b1;  // list line went into the buffer too
                    state        <= cmp_pkg::ST_FIFO_RST;
                end
                cmp_pkg::ST_FIFO_RST: begin
                    if (fifo_empty && !fifo_ptr_rst) state <= cmp_pkg::ST_BURST;
                end
                cmp_pkg::ST_BURST: begin
                    if (rd_resp.rvalid && rd_resp.rresp != '0) begin
                        state <= cmp_pkg::ST_BUS_ERR;
                    end else if (fifo_full) begin
                        comp_start <= 1'b1;  // whole page buffered
                        state      <= cmp_pkg::ST_COMP_WAIT;
                    end else if (burst_cnt != (LW+1)'(`CMP_PAGE_LINES)
                                 && !rd_req.arvalid && !outstanding) begin
                        rd_req.arvalid <= 1'b1;
                        rd_req.addr    <= {entry.way, burst_cnt[LW-1:0], 6'b00_0000};
                        burst_cnt      <= burst_cnt + 1'b1;
                    end
                end
                cmp_pkg::ST_COMP_WAIT: begin
                    if (comp_done) begin
                        comp_start <= 1'b0;
                        state      <= cmp_pkg::ST_LOOKUP;
                    end
                end
                cmp_pkg::ST_LOOKUP: begin
                    if (uc_vld[sidx]) begin
                        // fetch the open zspage metadata
                        rd_req.arvalid <= 1'b1;
                        rd_req.addr    <= {uc_way[sidx], 12'h000};
                        state          <= cmp_pkg::ST_WAIT_ZSPG;
                    end else begin
                        state <= cmp_pkg::ST_PREP_ZSPG;
                    end
                end
                cmp_pkg::ST_PREP_ZSPG: begin
                    if (wr_ready) begin
                        if ((csize + `CMP_ZS_OFFSET) < 4096) begin
                            uc_vld[sidx]     <= 1'b1;  // own way becomes the zspage
                            zspg_pkt         <= '{update:     1'b1,
                                                  iway:       entry.way,
                                                  free_start: way_base
                                                      + cmp_pkg::byte_addr_t'(`CMP_ZS_OFFSET),
                                                  cpage_size: csize,
                                                  next_way:   '0};
                            tol_upd.dst_list <= cmp_pkg::IFL_SIZE1;
                            state            <= cmp_pkg::ST_UPD_ATT;
                        end else begin
                            state <= cmp_pkg::ST_SIZE_ERR;
                        end
                    end
                end
                cmp_pkg::ST_WAIT_ZSPG: begin
                    if (rd_resp.rvalid) begin
                        state <= (rd_resp.rresp != '0) ? cmp_pkg::ST_BUS_ERR
                                                       : cmp_pkg::ST_MIGRATE;
                    end
                end
                cmp_pkg::ST_MIGRATE: begin
                    if (wr_ready && fits) begin
                        zspg_pkt <= '{update: 1'b1, iway: md.way0, free_start: zs_next,
                                      cpage_size: csize, next_way: md.next_way};
                        state    <= cmp_pkg::ST_FINAL_UPD;
                    end else if (wr_ready) begin
                        // no room, chain this way behind the zspage
                        zspg_pkt <= '{update: 1'b1, iway: md.way0, free_start: md.free_start,
                                      cpage_size: md.last_size, next_way: entry.way};
                        tol_upd.dst_list <= cmp_pkg::NULLIFY;
                        state            <= cmp_pkg::ST_UPD_ATT;
                    end
                end
                cmp_pkg::ST_UPD_ATT: begin
                    // updated level is stale while the pulse is still out
                    if (zspg_updated && wr_ready && !zspg_pkt.update) begin
                        tol_upd <= '{tbl_update: 1'b1, entry_id: list_head,
                                     new_way: zspg_pkt.free_start, src_list: cmp_pkg::UNCOMP,
                                     dst_list: tol_upd.dst_list, size_idx: sidx};
                        state   <= cmp_pkg::ST_PEEK;  // keep going, no free way yet
                    end
                end
                cmp_pkg::ST_FINAL_UPD: begin
                    if (zspg_updated && wr_ready && !zspg_pkt.update) begin
                        tol_upd <= '{tbl_update: 1'b1, entry_id: list_head,
                                     new_way: way_base, src_list: cmp_pkg::UNCOMP,
                                     dst_list: cmp_pkg::UNCOMP, size_idx: sidx};
                        state   <= cmp_pkg::ST_DONE;
                    end
                end
                cmp_pkg::ST_DONE: begin
                    done     <= 1'b1;
                    free_way <= entry.way;  // page moved out, whole way is free
                    state    <= cmp_pkg::ST_IDLE;
                end
                cmp_pkg::ST_SIZE_ERR, cmp_pkg::ST_BUS_ERR: begin
                    state <= state;  // sticky until reset
                end
                default: state <= cmp_pkg::ST_IDLE;
            endcase
        end
    end

    // payload, no reset
    always_ff @(posedge clk_i) begin
        if (state == cmp_pkg::ST_WAIT_LIST && rd_resp.rvalid) begin
            entry <= cmp_pkg::list_entry_t'(rd_resp.rdata[$bits(cmp_pkg::list_entry_t)-1:0]);
        end
        if (state == cmp_pkg::ST_COMP_WAIT && comp_done) csize <= comp_size;
        if (state == cmp_pkg::ST_LOOKUP && !uc_vld[sidx]) uc_way[sidx] <= entry.way;
        if (state == cmp_pkg::ST_WAIT_ZSPG && rd_resp.rvalid) begin
            md <= cmp_pkg::zspg_md_t'(rd_resp.rdata[$bits(cmp_pkg::zspg_md_t)-1:0]);
        end
    end

endmodule

`default_nettype wire

/* src/cmp_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cmp_top (
    input  wire                     clk_i,
    input  wire                     rst_ni,
    input  wire                     trigger,
    input  wire cmp_pkg::entry_id_t list_head,
    output cmp_pkg::rd_req_t        rd_req,
    input  wire                     arready,
    input  wire cmp_pkg::rd_resp_t  rd_resp,
    output cmp_pkg::wr_req_t        wr_req,
    input  wire                     wready,
    output cmp_pkg::tol_upd_t       tol_upd,
    output logic                    done,
    output cmp_pkg::way_t           free_way,
    output logic                    bus_error,
    output logic                    size_error
);

    logic                fifo_push;
    logic                fifo_pop;
    cmp_pkg::line_t      fifo_pop_data;
    logic                fifo_full;
    logic                fifo_empty;
    logic                fifo_ptr_rst;
    logic                comp_start;
    logic                comp_done;
    cmp_pkg::comp_size_t comp_size;
    logic                wr_ready;
    logic                zspg_updated;
    cmp_pkg::zspg_pkt_t  zspg_pkt;

    // every good beat lands in the buffer
    // manager clears it before a page burst so only page lines stay
    assign fifo_push = rd_resp.rvalid && (rd_resp.rresp == '0);

    cmpresn_mngr i_cmpresn_mngr (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .trigger      (trigger),
        .list_head    (list_head),
        .rd_req       (rd_req),
        .arready      (arready),
        .rd_resp      (rd_resp),
        .fifo_full    (fifo_full),
        .fifo_empty   (fifo_empty),
        .fifo_ptr_rst (fifo_ptr_rst),
        .comp_start   (comp_start),
        .comp_done    (comp_done),
        .comp_size    (comp_size),
        .wr_ready     (wr_ready),
        .zspg_updated (zspg_updated),
        .zspg_pkt     (zspg_pkt),
        .tol_upd      (tol_upd),
        .done         (done),
        .free_way     (free_way),
        .bus_error    (bus_error),
        .size_error   (size_error)
    );

    page_line_fifo i_page_line_fifo (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .push      (fifo_push),
        .push_data (rd_resp.rdata),
        .pop       (fifo_pop),
        .pop_data  (fifo_pop_data),
        .full      (fifo_full),
        .empty     (fifo_empty),
        .ptr_rst   (fifo_ptr_rst)
    );

    zero_line_compressor i_zero_line_compressor (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .comp_start (comp_start),
        .pop        (fifo_pop),
        .pop_data   (fifo_pop_data),
        .empty      (fifo_empty),
        .comp_done  (comp_done),
        .comp_size  (comp_size)
    );

    zspg_wr_mngr i_zspg_wr_mngr (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .zspg_pkt     (zspg_pkt),
        .wr_ready     (wr_ready),
        .zspg_updated (zspg_updated),
        .wr_req       (wr_req),
        .wready       (wready)
    );

endmodule

`default_nettype wire

/* sim/tb_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
    input  wire                    clk_i,
    input  wire cmp_pkg::rd_req_t  rd_req,
    output logic                   arready,
    output cmp_pkg::rd_resp_t      rd_resp,
    input  wire cmp_pkg::wr_req_t  wr_req,
    output logic                   wready
);

    cmp_pkg::line_t      mem [cmp_pkg::byte_addr_t];  // sparse, unwritten lines read as zero
    cmp_pkg::byte_addr_t bad_addr;  // read of this line answers with an error
    cmp_pkg::byte_addr_t rd_addr;
    logic                rd_pend;   // request taken on the coming rising edge
    logic                ar_q;
    logic                w_q;
    cmp_pkg::rd_resp_t   resp_q;

    assign arready = ar_q;
    assign wready  = w_q;
    assign rd_resp = resp_q;

    initial begin
        bad_addr = '1;
        rd_addr  = '0;
        rd_pend  = 1'b0;
        ar_q     = 1'b0;
        w_q      = 1'b0;
        resp_q   = '0;
    end

    task automatic load_line(input cmp_pkg::byte_addr_t addr, input cmp_pkg::line_t data);
        mem[addr] = data;
    endtask

    task automatic set_bad_addr(input cmp_pkg::byte_addr_t addr);
        bad_addr = addr;
    endtask

    // everything moves on the falling edge, the DUT samples on the rising one
    always @(negedge clk_i) begin
        resp_q = '0;  // rvalid lasts one cycle
        if (rd_pend) begin
            resp_q.rvalid = 1'b1;
            resp_q.rresp  = (rd_addr == bad_addr) ? 2'b10 : 2'b00;
            resp_q.rdata  = mem.exists(rd_addr) ? mem[rd_addr] : '0;
        end
        ar_q    = ($urandom % 4) != 0;  // random back-pressure, about one in four
        w_q     = ($urandom % 4) != 0;
        rd_pend = rd_req.arvalid && ar_q;
        if (rd_pend) rd_addr = rd_req.addr;
        if (wr_req.wvalid && w_q) mem[wr_req.addr] = wr_req.wdata;  // taken next edge
    end

endmodule

`default_nettype wire

/* sim/tb_cmp_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cmp_defs.svh"

module tb_cmp_top;

    localparam int N_PAGES   = 5;
    localparam int LOG_DEPTH = 8;
    localparam int TIMEOUT   = 4000;  // cycles per wait

    logic                clk_i;
    logic                rst_ni;
    logic                trigger;
    cmp_pkg::entry_id_t  list_head;
    cmp_pkg::rd_req_t    rd_req;
    logic                arready;
    cmp_pkg::rd_resp_t   rd_resp;
    cmp_pkg::wr_req_t    wr_req;
    logic                wready;
    cmp_pkg::tol_upd_t   tol_upd;
    logic                done;
    cmp_pkg::way_t       free_way;
    logic                bus_error;
    logic                size_error;

    cmp_pkg::way_t       page_way [N_PAGES];
    int                  page_nz [N_PAGES];  // nonzero lines per page

    // reference zspage state per size class
    logic [`CMP_SIZE_CLASSES-1:0] zs_open;
    cmp_pkg::way_t       zs_way0 [`CMP_SIZE_CLASSES];
    cmp_pkg::way_t       zs_link [`CMP_SIZE_CLASSES];
    cmp_pkg::byte_addr_t zs_free [`CMP_SIZE_CLASSES];
    cmp_pkg::comp_size_t zs_last [`CMP_SIZE_CLASSES];

    // observed traffic
    cmp_pkg::byte_addr_t wr_log_addr [LOG_DEPTH];
    cmp_pkg::line_t      wr_log_data [LOG_DEPTH];
    cmp_pkg::tol_upd_t   upd_log [LOG_DEPTH];
    cmp_pkg::way_t       done_log [LOG_DEPTH];
    int                  wr_cnt;
    int                  upd_cnt;
    int                  done_cnt;

    cmp_top i_cmp_top (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .trigger    (trigger),
        .list_head  (list_head),
        .rd_req     (rd_req),
        .arready    (arready),
        .rd_resp    (rd_resp),
        .wr_req     (wr_req),
        .wready     (wready),
        .tol_upd    (tol_upd),
        .done       (done),
        .free_way   (free_way),
        .bus_error  (bus_error),
        .size_error (size_error)
    );

    tb_mem_model i_mem (
        .clk_i   (clk_i),
        .rd_req  (rd_req),
        .arready (arready),
        .rd_resp (rd_resp),
        .wr_req  (wr_req),
        .wready  (wready)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // list manager stand-in, head moves on every table update
    always @(negedge clk_i) begin
        if (tol_upd.tbl_update) list_head <= list_head + 1'b1;
    end

    always @(posedge clk_i) begin
        if (wr_req.wvalid && wready && wr_cnt < LOG_DEPTH) begin
            wr_log_addr[wr_cnt] <= wr_req.addr;
            wr_log_data[wr_cnt] <= wr_req.wdata;
            wr_cnt              <= wr_cnt + 1;
        end
        if (tol_upd.tbl_update && upd_cnt < LOG_DEPTH) begin
            upd_log[upd_cnt] <= tol_upd;
            upd_cnt          <= upd_cnt + 1;
        end
        if (done && done_cnt < LOG_DEPTH) begin
            done_log[done_cnt] <= free_way;
            done_cnt           <= done_cnt + 1;
        end
    end

    task automatic abort_sim(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got == exp)
            else abort_sim($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic check_quiet();
        check_val("rd_req.arvalid", 64'(rd_req.arvalid), 64'h0);
        check_val("wr_req.wvalid", 64'(wr_req.wvalid), 64'h0);
        check_val("tol_upd.tbl_update", 64'(tol_upd.tbl_update), 64'h0);
        check_val("done", 64'(done), 64'h0);
        check_val("bus_error", 64'(bus_error), 64'h0);
        check_val("size_error", 64'(size_error), 64'h0);
    endtask

    function automatic int log_count(input int which);
        case (which)
            0:       return wr_cnt;
            1:       return upd_cnt;
            default: return done_cnt;
        endcase
    endfunction

    task automatic wait_for_log(input int which, input int target, input string what);
        int cycles;
        cycles = 0;
        while (log_count(which) < target) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) abort_sim($sformatf("timeout waiting for %s", what));
        end
    endtask

    // list entries plus page lines, nonzero lines at random positions
    task automatic load_pages();
        int                   p;
        int                   l;
        int                   cnt;
        int                   pos;
        logic [63:0]          used;
        cmp_pkg::byte_addr_t  a;
        cmp_pkg::list_entry_t le;
        for (p = 0; p < N_PAGES; p++) begin
            le.way  = page_way[p];
            le.attr = 28'(p);
            i_mem.load_line(`CMP_LIST_BASE + cmp_pkg::byte_addr_t'(p * 64), cmp_pkg::line_t'(le));
            used = '0;
            cnt  = 0;
            while (cnt < page_nz[p]) begin
                pos = $urandom % 64;
                if (!used[pos]) begin
                    used[pos] = 1'b1;
                    cnt++;
                end
            end
            for (l = 0; l < `CMP_PAGE_LINES; l++) begin
                a = {page_way[p], 6'(l), 6'b00_0000};
                i_mem.load_line(a, used[l] ? cmp_pkg::line_t'({$urandom, $urandom, a}) : '0);
            end
        end
    endtask

    initial begin
        int                  p;
        int                  i;
        int                  cycles;
        int                  exp_done;
        logic                appended;
        cmp_pkg::comp_size_t size;
        cmp_pkg::size_idx_t  cls;
        cmp_pkg::byte_addr_t base;
        cmp_pkg::byte_addr_t nf;
        cmp_pkg::byte_addr_t end_addr;
        cmp_pkg::byte_addr_t exp_new;
        cmp_pkg::list_id_e   exp_dst;
        cmp_pkg::zspg_md_t   md;
        cmp_pkg::tol_upd_t   upd;
        rst_ni    = 1'b0;
        trigger   = 1'b0;
        list_head = '0;
        wr_cnt    = 0;
        upd_cnt   = 0;
        done_cnt  = 0;
        zs_open   = '0;
        exp_done  = 0;
        void'($urandom(32'h9824a225));

        // class 2 opens, class 2 appends, class 11 opens, class 11 overflows, class 2 appends
        page_way[0] = 36'h321;
        page_nz[0]  = 9;
        page_way[1] = 36'h322;
        page_nz[1]  = 10;
        page_way[2] = 36'h5a3;
        page_nz[2]  = 44;
        page_way[3] = 36'h5a4;
        page_nz[3]  = 44;
        page_way[4] = 36'h777;
        page_nz[4]  = 7;
        load_pages();

        for (i = 0; i < 16; i++) begin
            @(negedge clk_i);
            check_quiet();
        end
        rst_ni = 1'b1;
        for (i = 0; i < 3; i++) begin
            @(negedge clk_i);
            check_quiet();
        end
        // entry after the last page
        i_mem.set_bad_addr(`CMP_LIST_BASE + cmp_pkg::byte_addr_t'(N_PAGES * 64));
        trigger = 1'b1;

        for (p = 0; p < N_PAGES; p++) begin
            size     = cmp_pkg::comp_size_t'(64 * page_nz[p] + 64);  // kept lines + header
            cls      = cmp_pkg::size_idx_t'(size / 256);
            base     = {page_way[p], 12'h000};
            appended = 1'b0;
            if (!zs_open[cls]) begin
                // new zspage inside the page's own way
                zs_open[cls] = 1'b1;
                zs_way0[cls] = page_way[p];
                zs_link[cls] = '0;
                zs_free[cls] = base + cmp_pkg::byte_addr_t'(`CMP_ZS_OFFSET);
                zs_last[cls] = size;
                exp_dst      = cmp_pkg::IFL_SIZE1;
                exp_new      = zs_free[cls];
            end else begin
                nf       = zs_free[cls] + cmp_pkg::byte_addr_t'(zs_last[cls]);
                end_addr = nf + cmp_pkg::byte_addr_t'(size);
                if (end_addr[`CMP_ADDR_W-1:12] == zs_way0[cls]) begin
                    appended     = 1'b1;  // same 4 KB frame
                    zs_free[cls] = nf;
                    zs_last[cls] = size;
                    exp_dst      = cmp_pkg::UNCOMP;
                    exp_new      = base;
                end else begin
                    zs_link[cls] = page_way[p];  // chained, metadata otherwise kept
                    exp_dst      = cmp_pkg::NULLIFY;
                    exp_new      = zs_free[cls];
                end
            end

            wait_for_log(0, p + 1, "metadata write");
            check_val("done count", 64'(done_cnt), 64'(exp_done));
            md = cmp_pkg::zspg_md_t'(wr_log_data[p][$bits(cmp_pkg::zspg_md_t)-1:0]);
            check_val("wr_req.addr", 64'(wr_log_addr[p]), 64'({zs_way0[cls], 12'h000}));
            check_val("md.way0", 64'(md.way0), 64'(zs_way0[cls]));
            check_val("md.next_way", 64'(md.next_way), 64'(zs_link[cls]));
            check_val("md.free_start", 64'(md.free_start), 64'(zs_free[cls]));
            check_val("md.last_size", 64'(md.last_size), 64'(zs_last[cls]));

            wait_for_log(1, p + 1, "list update");
            upd = upd_log[p];
            check_val("tol_upd.entry_id", 64'(upd.entry_id), 64'(8'(p)));
            check_val("tol_upd.new_way", 64'(upd.new_way), 64'(exp_new));
            check_val("tol_upd.src_list", 64'(upd.src_list), 64'(cmp_pkg::UNCOMP));
            check_val("tol_upd.dst_list", 64'(upd.dst_list), 64'(exp_dst));
            check_val("tol_upd.size_idx", 64'(upd.size_idx), 64'(cls));

            if (appended) begin
                exp_done++;
                wait_for_log(2, exp_done, "done pulse");
                check_val("free_way", 64'(done_log[exp_done-1]), 64'(page_way[p]));
            end
        end

        // next list read fails
        cycles = 0;
        while (!bus_error) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_sim("timeout waiting for bus_error after a failed list read");
            end
        end
        for (i = 0; i < 200; i++) begin
            @(negedge clk_i);
            check_val("done", 64'(done), 64'h0);
            check_val("bus_error", 64'(bus_error), 64'h1);
            check_val("size_error", 64'(size_error), 64'h0);
        end
        check_val("done count", 64'(done_cnt), 64'(exp_done));
        check_val("write count", 64'(wr_cnt), 64'(N_PAGES));
        check_val("update count", 64'(upd_cnt), 64'(N_PAGES));

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
src/cmp_pkg.sv
src/page_line_fifo.sv
src/zero_line_compressor.sv
src/zspg_wr_mngr.sv
src/cmpresn_mngr.sv
src/cmp_top.sv
sim/tb_mem_model.sv
sim/tb_cmp_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the compaction manager testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f build.f --top-module tb_cmp_top
./obj_dir/Vtb_cmp_top | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "run failed, see sim.log"
    exit 1
fi
grep -q "Simulation PASSED" sim.log
